/* design/exec_macros.svh */
// execute slice global sizes
// data width and architectural register file geometry

`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// integer datapath width
`define XLEN        32

// architectural registers, x0 included
`define REG_COUNT   32

// register index width, log2 of REG_COUNT
`define REG_ADDR_W  5

`endif

/* design/exec_pkg.sv */
// execute slice package
// ALU operation encoding and RV32I major opcode / funct3 constants

`default_nettype none

package exec_pkg;

    // ALU operation selected by the decoder
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_XOR,
        ALU_AND,
        ALU_SLT,
        ALU_SLTU,
        ALU_LUI     // passes operand b through
    } alu_op_t;

    // major opcodes, instr[6:0]
    localparam logic [6:0] OPC_OP     = 7'b0110011;  // register-register
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // register-immediate
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // funct3, instr[14:12]
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;  // srl/sra, bit 30 picks
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

endpackage

`default_nettype wire

/* design/instr_decoder.sv */
// instruction decoder
// checks the RV32I ALU subset, picks the ALU operation and builds operands,
// then registers everything into the execute stage

`default_nettype none

`include "exec_macros.svh"

module instr_decoder
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instr_valid,
    input  logic [31:0]             instr,
    input  logic [`XLEN-1:0]        fwd_a,      // forwarded rs1
    input  logic [`XLEN-1:0]        fwd_b,      // forwarded rs2
    output logic                    ex_valid,
    output exec_pkg::alu_op_t       ex_op,
    output logic [`XLEN-1:0]        ex_a,
    output logic [`XLEN-1:0]        ex_b,
    output logic [`REG_ADDR_W-1:0]  ex_rd
);

    import exec_pkg::*;

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    logic               f7_zero;    // funct7 all zero
    logic               f7_alt;     // only bit 30 set
    logic [`XLEN-1:0]   imm_i;
    logic [`XLEN-1:0]   imm_u;
    logic               dec_ok;     // encoding is in the supported set
    alu_op_t            dec_op;
    logic [`XLEN-1:0]   dec_b;

    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);
    assign imm_i   = {{(`XLEN-12){instr[31]}}, instr[31:20]};  // sign extended
    assign imm_u   = {instr[31:12], 12'b0};

    always_comb
    begin
        // funct3 -> op, shared by OP and OP_IMM
        case (funct3)
            F3_ADD_SUB: dec_op = (opcode == OPC_OP && instr[30]) ? ALU_SUB : ALU_ADD;
            F3_SLL:     dec_op = ALU_SLL;
            F3_SLT:     dec_op = ALU_SLT;
            F3_SLTU:    dec_op = ALU_SLTU;
            F3_XOR:     dec_op = ALU_XOR;
            F3_SR:      dec_op = instr[30] ? ALU_SRA : ALU_SRL;
            F3_OR:      dec_op = ALU_OR;
            default:    dec_op = ALU_AND;
        endcase
        dec_b  = fwd_b;
        dec_ok = 1'b0;
        case (opcode)
            OPC_OP:
                dec_ok = f7_zero || (f7_alt && (funct3 == F3_ADD_SUB || funct3 == F3_SR));
            OPC_OP_IMM:
            begin
                dec_b = imm_i;  // shamt sits in imm[4:0]
                if (funct3 == F3_SLL)
                    dec_ok = f7_zero;
                else if (funct3 == F3_SR)
                    dec_ok = f7_zero || f7_alt;
                else
                    dec_ok = 1'b1;
            end
            OPC_LUI:
            begin
                dec_op = ALU_LUI;
                dec_b  = imm_u;
                dec_ok = 1'b1;
            end
            default: dec_ok = 1'b0;  // dropped, becomes a bubble
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ex_valid <= 1'b0;
            ex_op    <= ALU_ADD;
            ex_a     <= '0;
            ex_b     <= '0;
            ex_rd    <= '0;
        end
        else
        begin
            ex_valid <= instr_valid && dec_ok;
            ex_op    <= dec_op;
            ex_a     <= fwd_a;
            ex_b     <= dec_b;
            ex_rd    <= instr[11:7];
        end
    end

endmodule

`default_nettype wire

/* design/operand_bypass.sv */
// operand bypass
// picks the youngest in-flight value for each source register,
// falling back to the register file

`default_nettype none

`include "exec_macros.svh"

module operand_bypass
(
    input  logic [`REG_ADDR_W-1:0]  rs1,
    input  logic [`REG_ADDR_W-1:0]  rs2,
    input  logic [`XLEN-1:0]        rf_a,       // register file port a
    input  logic [`XLEN-1:0]        rf_b,       // register file port b
    input  logic                    ex_valid,   // alu stage, youngest
    input  logic [`REG_ADDR_W-1:0]  ex_rd,
    input  logic [`XLEN-1:0]        ex_result,
    input  logic                    wb_valid,   // writeback stage, older
    input  logic [`REG_ADDR_W-1:0]  wb_rd,
    input  logic [`XLEN-1:0]        wb_data,
    output logic [`XLEN-1:0]        fwd_a,
    output logic [`XLEN-1:0]        fwd_b
);

    // resolve one source against both pipeline stages
    function automatic logic [`XLEN-1:0] resolve(
        input logic [`REG_ADDR_W-1:0] rs,
        input logic [`XLEN-1:0]       rf
    );
        if (rs == '0)
            resolve = rf;           // x0 never forwarded, file reads zero
        else if (ex_valid && ex_rd == rs)
            resolve = ex_result;    // result still in the alu
        else if (wb_valid && wb_rd == rs)
            resolve = wb_data;      // being written this edge
        else
            resolve = rf;
    endfunction

    // reacts to the stage signals read inside resolve as well
    always_comb
    begin
        fwd_a = resolve(rs1, rf_a);
        fwd_b = resolve(rs2, rf_b);
    end

endmodule

`default_nettype wire

/* design/reg_file.sv */
// integer register file
// 31 writable registers plus hard-wired x0, two async read ports,
// one synchronous write port

`default_nettype none

`include "exec_macros.svh"

module reg_file
#(
    parameter int unsigned NUM_REGS = `REG_COUNT
)
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`REG_ADDR_W-1:0]  ra_a,
    input  logic [`REG_ADDR_W-1:0]  ra_b,
    input  logic                    we,
    input  logic [`REG_ADDR_W-1:0]  wa,
    input  logic [`XLEN-1:0]        wd,
    output logic [`XLEN-1:0]        rd_a,
    output logic [`XLEN-1:0]        rd_b
);

    logic [`XLEN-1:0] regs [1:NUM_REGS-1];  // no storage for x0

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 1; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (we && wa != '0)    // x0 writes ignored here
            regs[wa] <= wd;
    end

    // async reads, x0 forced to zero
    assign rd_a = (ra_a == '0) ? '0 : regs[ra_a];
    assign rd_b = (ra_b == '0) ? '0 : regs[ra_b];

endmodule

`default_nettype wire

/* design/alu.sv */
// integer ALU
// add/sub with carry, shifts, logic ops, set-less-than and LUI pass,
// result exposed for forwarding and registered into writeback

`default_nettype none

`include "exec_macros.svh"

module alu
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ex_valid,
    input  exec_pkg::alu_op_t       ex_op,
    input  logic [`XLEN-1:0]        ex_a,
    input  logic [`XLEN-1:0]        ex_b,
    input  logic [`REG_ADDR_W-1:0]  ex_rd,
    output logic [`XLEN-1:0]        ex_result,  // to bypass, combinational
    output logic                    wb_valid,
    output logic [`REG_ADDR_W-1:0]  wb_rd,
    output logic [`XLEN-1:0]        wb_data
);

    import exec_pkg::*;

    logic [`XLEN:0]     add_sub;    // extra bit holds carry / borrow
    logic               borrow;     // a < b unsigned
    logic               sign;
    logic               sof;        // subtraction overflow
    logic [4:0]         shamt;
    logic [`XLEN-1:0]   shift_res;
    logic [`XLEN-1:0]   logic_res;

    assign shamt = ex_b[4:0];

    always_comb
    begin
        if (ex_op == ALU_ADD)
            add_sub = {1'b0, ex_a} + {1'b0, ex_b};
        else
            add_sub = {1'b0, ex_a} - {1'b0, ex_b};  // sub, slt, sltu
    end

    assign borrow = add_sub[`XLEN];
    assign sign   = add_sub[`XLEN-1];
    // operands of different sign and result sign flipped from a
    assign sof    = (ex_a[`XLEN-1] != ex_b[`XLEN-1]) && (sign != ex_a[`XLEN-1]);

    always_comb
    begin
        case (ex_op)
            ALU_SRL: shift_res = ex_a >> shamt;
            ALU_SRA: shift_res = $signed(ex_a) >>> shamt;  // sign fill
            default: shift_res = ex_a << shamt;
        endcase
    end

    always_comb
    begin
        case (ex_op)
            ALU_XOR: logic_res = ex_a ^ ex_b;
            ALU_AND: logic_res = ex_a & ex_b;
            default: logic_res = ex_a | ex_b;
        endcase
    end

    always_comb
    begin
        case (ex_op)
            ALU_SLL, ALU_SRL, ALU_SRA: ex_result = shift_res;
            ALU_OR, ALU_XOR, ALU_AND:  ex_result = logic_res;
            ALU_SLT:  ex_result = {{(`XLEN-1){1'b0}}, sign ^ sof};
            ALU_SLTU: ex_result = {{(`XLEN-1){1'b0}}, borrow};
            ALU_LUI:  ex_result = ex_b;                 // upper imm already placed
            default:  ex_result = add_sub[`XLEN-1:0];   // add, sub
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wb_valid <= 1'b0;
            wb_rd    <= '0;
            wb_data  <= '0;
        end
        else
        begin
            wb_valid <= ex_valid;   // bubbles pass through low
            wb_rd    <= ex_rd;
            wb_data  <= ex_result;
        end
    end

endmodule

`default_nettype wire

/* design/exec_unit_top.sv */
// execute slice top level
// decoder -> alu two-stage pipe with bypass and register file writeback

`default_nettype none

`include "exec_macros.svh"

module exec_unit_top
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instr_valid,
    input  logic [31:0]             instr,
    output logic                    wb_valid,
    output logic [`REG_ADDR_W-1:0]  wb_rd,
    output logic [`XLEN-1:0]        wb_data
);

    import exec_pkg::*;

    logic [`XLEN-1:0]       rf_a;       // raw file reads
    logic [`XLEN-1:0]       rf_b;
    logic [`XLEN-1:0]       fwd_a;      // after bypass
    logic [`XLEN-1:0]       fwd_b;
    logic                   ex_valid;
    alu_op_t                ex_op;
    logic [`XLEN-1:0]       ex_a;
    logic [`XLEN-1:0]       ex_b;
    logic [`REG_ADDR_W-1:0] ex_rd;
    logic [`XLEN-1:0]       ex_result;  // alu next result

    instr_decoder i_instr_decoder
    (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .ex_valid    (ex_valid),
        .ex_op       (ex_op),
        .ex_a        (ex_a),
        .ex_b        (ex_b),
        .ex_rd       (ex_rd)
    );

    operand_bypass i_operand_bypass
    (
        .rs1       (instr[19:15]),
        .rs2       (instr[24:20]),
        .rf_a      (rf_a),
        .rf_b      (rf_b),
        .ex_valid  (ex_valid),
        .ex_rd     (ex_rd),
        .ex_result (ex_result),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b)
    );

    // read addresses straight from the instruction fields
    reg_file #(.NUM_REGS(`REG_COUNT)) i_reg_file
    (
        .clk  (clk),
        .rst  (rst),
        .ra_a (instr[19:15]),
        .ra_b (instr[24:20]),
        .we   (wb_valid),
        .wa   (wb_rd),
        .wd   (wb_data),
        .rd_a (rf_a),
        .rd_b (rf_b)
    );

    alu i_alu
    (
        .clk       (clk),
        .rst       (rst),
        .ex_valid  (ex_valid),
        .ex_op     (ex_op),
        .ex_a      (ex_a),
        .ex_b      (ex_b),
        .ex_rd     (ex_rd),
        .ex_result (ex_result),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

endmodule

`default_nettype wire

/* tb/exec_unit_tb.sv */
// execute slice testbench
// directed and random RV32I ALU traffic against a register-array reference model,
// checks each writeback value, destination and latency

`default_nettype none

module exec_unit_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import exec_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_SLOTS  = 300;    // issue slots incl. bubbles

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        instr_valid = 1'b0;
    logic [31:0] instr = 32'h0;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    logic [31:0] model_regs [32];   // architectural state seen at issue
    logic [4:0]  exp_rd_q [$];
    logic [31:0] exp_data_q [$];
    int          exp_cycle_q [$];   // cycle the strobe is due in
    int          cycle_cnt = 0;
    int          slots_used = 0;

    exec_unit_top i_exec_unit_top
    (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk)
        cycle_cnt <= cycle_cnt + 1;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
            stop_run($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
    endtask

    function automatic logic [31:0] make_r(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        make_r = {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] make_i(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        make_i = {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] make_lui(input logic [19:0] imm, input logic [4:0] rd);
        make_lui = {imm, rd, OPC_LUI};
    endfunction

    // RV32I rules for which encodings exist in the ALU subset
    function automatic logic is_supported(input logic [31:0] ins);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = ins[31:25];
        f3 = ins[14:12];
        case (ins[6:0])
            OPC_OP:
                is_supported = (f7 == 7'h00) ||
                               (f7 == 7'h20 && (f3 == F3_ADD_SUB || f3 == F3_SR));
            OPC_OP_IMM:
            begin
                if (f3 == F3_SLL)
                    is_supported = (f7 == 7'h00);   // slli
                else if (f3 == F3_SR)
                    is_supported = (f7 == 7'h00 || f7 == 7'h20);
                else
                    is_supported = 1'b1;
            end
            OPC_LUI: is_supported = 1'b1;
            default: is_supported = 1'b0;
        endcase
    endfunction

    // reference result from the model registers
    function automatic logic [31:0] ref_result(input logic [31:0] ins);
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        a = model_regs[ins[19:15]];
        if (ins[6:0] == OPC_OP)
            b = model_regs[ins[24:20]];
        else
            b = {{20{ins[31]}}, ins[31:20]};   // I-type imm, sign extended
        sh = b[4:0];
        ref_result = 32'h0;
        if (ins[6:0] == OPC_LUI)
            ref_result = {ins[31:12], 12'h000};
        else
        begin
            case (ins[14:12])
                F3_ADD_SUB: ref_result = (ins[6:0] == OPC_OP && ins[30]) ? a - b : a + b;
                F3_SLL:     ref_result = a << sh;
                F3_SLT:     ref_result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                F3_SLTU:    ref_result = (a < b) ? 32'd1 : 32'd0;
                F3_XOR:     ref_result = a ^ b;
                F3_SR:
                begin
                    if (ins[30])
                        ref_result = $signed(a) >>> sh;  // sign fill
                    else
                        ref_result = a >> sh;
                end
                F3_OR:      ref_result = a | b;
                default:    ref_result = a & b;
            endcase
        end
    endfunction

    // one instruction for one cycle, expectation queued at issue
    task automatic issue(input logic [31:0] ins);
        logic [31:0] val;
        instr_valid = 1'b1;
        instr       = ins;
        if (is_supported(ins))
        begin
            val = ref_result(ins);
            exp_rd_q.push_back(ins[11:7]);
            exp_data_q.push_back(val);
            exp_cycle_q.push_back(cycle_cnt + 2);
            if (ins[11:7] != 5'd0)
                model_regs[ins[11:7]] = val;    // x0 stays zero
        end
        slots_used++;
        @(posedge clk);
        #10;
        instr_valid = 1'b0;
    endtask

    task automatic idle_cycle();
        instr_valid = 1'b0;
        instr       = $urandom;     // junk while invalid
        slots_used++;
        @(posedge clk);
        #10;
    endtask

    function automatic logic [31:0] rand_instr(input int kind);
        logic [31:0] w;
        logic [31:0] v;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [6:0]  f7;
        logic [11:0] imm;
        w   = $urandom;
        v   = $urandom;
        rd  = {2'b00, w[2:0]};  // x0..x7 for dense dependencies
        rs1 = {2'b00, w[5:3]};
        rs2 = {2'b00, w[8:6]};
        f3  = w[11:9];
        alt = w[12];
        case (kind)
            0, 1, 2, 3:
            begin
                f7 = (alt && (f3 == F3_ADD_SUB || f3 == F3_SR)) ? 7'h20 : 7'h00;
                rand_instr = make_r(f7, rs2, rs1, f3, rd);
            end
            4, 5, 6:
            begin
                imm = v[11:0];
                if (f3 == F3_SLL)
                    imm[11:5] = 7'h00;
                else if (f3 == F3_SR)
                    imm[11:5] = alt ? 7'h20 : 7'h00;
                rand_instr = make_i(imm, rs1, f3, rd);
            end
            7: rand_instr = make_lui(v[19:0], rd);
            default:
            begin
                if (alt)
                    rand_instr = make_r(7'h01, rs2, rs1, f3, rd);  // M ext, not here
                else
                    rand_instr = {v[24:0], 7'b0000011};           // load
            end
        endcase
    endfunction

    task automatic run_directed();
        issue(make_lui(20'h80000, 5'd1));                // x1 = most negative
        issue(make_i(12'hfff, 5'd1, F3_ADD_SUB, 5'd2));  // x2 = max positive, 1 back
        issue(make_i(12'hfff, 5'd0, F3_ADD_SUB, 5'd3));  // x3 = -1
        issue(make_i(12'h001, 5'd0, F3_ADD_SUB, 5'd4));  // x4 = 1
        // slt / sltu across the sign boundary, equal pairs on the diagonal
        for (int ra = 1; ra <= 4; ra++)
        begin
            for (int rb = 1; rb <= 4; rb++)
            begin
                issue(make_r(7'h00, rb[4:0], ra[4:0], F3_SLT, 5'd5));
                issue(make_r(7'h00, rb[4:0], ra[4:0], F3_SLTU, 5'd6));
            end
        end
        issue(make_i(12'h800, 5'd2, F3_SLT, 5'd7));      // negative imm
        issue(make_i(12'hfff, 5'd3, F3_SLTU, 5'd7));
        issue(make_i({7'h20, 5'd4}, 5'd1, F3_SR, 5'd5)); // srai
        issue(make_i({7'h00, 5'd4}, 5'd1, F3_SR, 5'd6)); // srli
        issue(make_r(7'h20, 5'd4, 5'd1, F3_SR, 5'd7));   // sra by x4
        issue(make_i(12'h123, 5'd3, F3_ADD_SUB, 5'd0));  // write x0, strobe still out
        issue(make_r(7'h00, 5'd0, 5'd0, F3_ADD_SUB, 5'd5));
        // dropped encodings must not touch x4
        issue(make_r(7'h01, 5'd4, 5'd3, F3_ADD_SUB, 5'd4));
        issue({25'h1ab_cd12, 7'b0000011} | 32'h0000_0200);
        issue(make_i({7'h20, 5'd1}, 5'd1, F3_SLL, 5'd4));
        issue(make_r(7'h00, 5'd0, 5'd4, F3_ADD_SUB, 5'd5));
        // chains through the alu and writeback bypass
        issue(make_i(12'h007, 5'd8, F3_ADD_SUB, 5'd8));
        issue(make_i(12'h007, 5'd8, F3_ADD_SUB, 5'd8));
        issue(make_i(12'h007, 5'd8, F3_ADD_SUB, 5'd8));
        issue(make_i(12'h005, 5'd0, F3_ADD_SUB, 5'd10));
        issue(make_i(12'h009, 5'd0, F3_ADD_SUB, 5'd11));
        issue(make_r(7'h00, 5'd11, 5'd10, F3_ADD_SUB, 5'd12));  // 2 back and 1 back
    endtask

    task automatic run_random();
        int kind;
        while (slots_used < NUM_SLOTS)
        begin
            kind = $urandom_range(0, 9);
            if (kind == 9)
                idle_cycle();
            else
                issue(rand_instr(kind));
        end
    endtask

    // compare every strobe with the head of the queue
    always @(negedge clk)
    begin
        logic [4:0]  e_rd;
        logic [31:0] e_data;
        int          e_cycle;
        if (!rst && wb_valid)
        begin
            if (exp_rd_q.size() == 0)
                stop_run("writeback strobe seen with no instruction outstanding");
            else
            begin
                e_rd    = exp_rd_q.pop_front();
                e_data  = exp_data_q.pop_front();
                e_cycle = exp_cycle_q.pop_front();
                check_value("wb_rd", {27'b0, wb_rd}, {27'b0, e_rd});
                check_value("wb_data", wb_data, e_data);
                check_value("wb_valid cycle", cycle_cnt, e_cycle);
            end
        end
    end

    initial
    begin
        #((NUM_SLOTS + 50) * CLK_PERIOD);
        stop_run("timeout, the run did not finish in time");
    end

    initial
    begin
        void'($urandom(32'h168a4c1d));
        foreach (model_regs[i])
            model_regs[i] = 32'h0;
        repeat (10) @(posedge clk);
        #10;
        rst = 1'b0;
        run_directed();
        run_random();
        repeat (4) @(negedge clk);  // drain the pipe
        if (exp_rd_q.size() != 0)
            stop_run("instructions still expected a writeback at the end of the run");
        else
        begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+design
design/exec_pkg.sv
design/instr_decoder.sv
design/operand_bypass.sv
design/reg_file.sv
design/alu.sv
design/exec_unit_top.sv
tb/exec_unit_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the execute slice testbench with Verilator and run it
# exit status is nonzero when the simulation stops on an error

cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/100ps \
    -f files.f --top-module exec_unit_tb -Mdir obj_dir &&
./obj_dir/Vexec_unit_tb || { echo "simulation failed"; exit 1; }
